//--- rtl/rv_pkg.sv
package rv_pkg;

  ////////////////////
  // widths
  ////////////////////

  // data word and instruction word
  localparam int unsigned XLEN = 32;
  localparam int unsigned ILEN = 32;
  // register index and register count
  localparam int unsigned RIDX_W = 5;
  localparam int unsigned NREG = 2 ** RIDX_W;
  // instruction fields
  localparam int unsigned OPC_W = 7;
  localparam int unsigned FN3_W = 3;

  typedef logic [XLEN-1:0] xlen_t;
  typedef logic [ILEN-1:0] inst_t;
  typedef logic [RIDX_W-1:0] reg_idx_t;
  typedef logic [FN3_W-1:0] fn3_t;

  ////////////////////
  // encodings
  ////////////////////

  // major opcodes of the kept RV32I subset
  typedef enum logic [OPC_W-1:0] {
    OP_IMM = 7'b0010011,
    OP     = 7'b0110011,
    LUI    = 7'b0110111,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    BRANCH = 7'b1100011,
    JAL    = 7'b1101111
  } opc_t;

  // ALU operations
  typedef enum logic [2:0] {
    ADD,
    SUB,
    AND,
    OR,
    XOR,
    // LUI only, the U immediate goes through unchanged
    PASS_B
  } alu_op_t;

  // funct3 for arithmetic and logic
  localparam fn3_t FN3_ADD = 3'b000;
  localparam fn3_t FN3_XOR = 3'b100;
  localparam fn3_t FN3_OR  = 3'b110;
  localparam fn3_t FN3_AND = 3'b111;
  // funct3 for branches
  localparam fn3_t FN3_BEQ = 3'b000;
  localparam fn3_t FN3_BNE = 3'b001;

  ////////////////////
  // immediates
  ////////////////////

  // I-type, loads and OP_IMM
  function automatic xlen_t imm_i(inst_t ins);
    return {{(XLEN-12){ins[31]}}, ins[31:20]};
  endfunction

  // S-type, stores
  function automatic xlen_t imm_s(inst_t ins);
    return {{(XLEN-12){ins[31]}}, ins[31:25], ins[11:7]};
  endfunction

  // B-type, bit 0 always zero
  function automatic xlen_t imm_b(inst_t ins);
    return {{(XLEN-13){ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
  endfunction

  // J-type, bit 0 always zero
  function automatic xlen_t imm_j(inst_t ins);
    return {{(XLEN-21){ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
  endfunction

  // U-type, lower 12 bits cleared
  function automatic xlen_t imm_u(inst_t ins);
    return {ins[31:12], 12'b0};
  endfunction

endpackage

//--- rtl/rv_gpr.sv
module rv_gpr (
  input  logic             clk,
  input  logic             rst,
  // read ports
  input  rv_pkg::reg_idx_t rs1_adr,
  input  rv_pkg::reg_idx_t rs2_adr,
  output rv_pkg::xlen_t    rs1_dat,
  output rv_pkg::xlen_t    rs2_dat,
  // write port
  input  rv_pkg::reg_idx_t rd_adr,
  input  logic             rd_wen,
  input  rv_pkg::xlen_t    rd_dat
);

  // register array, entry 0 is never written
  rv_pkg::xlen_t gpr_q [rv_pkg::NREG];

  // write on the retiring edge, x0 writes dropped
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      for (int i = 0; i < rv_pkg::NREG; i++) begin
        gpr_q[i] <= '0;
      end
    end else if (rd_wen && (rd_adr != '0)) begin
      gpr_q[rd_adr] <= rd_dat;
    end
  end

  // combinational reads, x0 reads as zero
  assign rs1_dat = (rs1_adr == '0) ? '0 : gpr_q[rs1_adr];
  assign rs2_dat = (rs2_adr == '0) ? '0 : gpr_q[rs2_adr];

  // the core must not retire anything while held in reset
  a_no_wen_in_rst: assert property (
    @(posedge clk) rst |-> !rd_wen
  );

endmodule

//--- rtl/rv_alu.sv
module rv_alu (
  // operation select
  input  rv_pkg::alu_op_t op,
  // operands
  input  rv_pkg::xlen_t   a,
  input  rv_pkg::xlen_t   b,
  // result and branch compare
  output rv_pkg::xlen_t   res,
  output logic            eq
);

  ////////////////////
  // shared subtractor
  ////////////////////

  // difference, used by SUB and by the branch compare
  rv_pkg::xlen_t diff;

  assign diff = a - b;

  // operands equal when the difference is zero
  assign eq = ~|diff;

  ////////////////////
  // result mux
  ////////////////////

  always_comb begin
    case (op)
      rv_pkg::ADD: begin
        res = a + b;
      end
      rv_pkg::SUB: begin
        res = diff;
      end
      // bitwise ops
      rv_pkg::AND: begin
        res = a & b;
      end
      rv_pkg::OR: begin
        res = a | b;
      end
      rv_pkg::XOR: begin
        res = a ^ b;
      end
      // upper immediate pass
      rv_pkg::PASS_B: begin
        res = b;
      end
      default: begin
        res = '0;
      end
    endcase
  end

endmodule

//--- rtl/rv_lsu.sv
module rv_lsu (
  input  logic          clk,
  input  logic          rst,
  // from decode
  input  logic          run,
  input  rv_pkg::opc_t  opc,
  input  rv_pkg::xlen_t base,
  input  rv_pkg::xlen_t ofs,
  input  rv_pkg::xlen_t wdt,
  // load/store bus
  output logic          lsu_vld,
  output logic          lsu_wen,
  output rv_pkg::xlen_t lsu_adr,
  output rv_pkg::xlen_t lsu_wdt,
  input  logic          lsu_rdy,
  input  rv_pkg::xlen_t lsu_rdt,
  // back to the core
  output rv_pkg::xlen_t rdt,
  output logic          stl
);

  ////////////////////
  // request
  ////////////////////

  // only LW and SW reach the bus
  logic is_ld;
  logic is_st;

  assign is_ld = (opc == rv_pkg::LOAD);
  assign is_st = (opc == rv_pkg::STORE);

  // valid level, held until the transfer retires
  assign lsu_vld = run & (is_ld | is_st);
  assign lsu_wen = is_st;

  // own address adder, base register plus I or S offset
  assign lsu_adr = base + ofs;

  // store data straight from rs2
  assign lsu_wdt = wdt;

  ////////////////////
  // response
  ////////////////////

  // memory answers in the transfer cycle
  assign rdt = lsu_rdt;

  // waiting on the data bus
  assign stl = lsu_vld & ~lsu_rdy;

  // request must not change under back-pressure
  // relies on the core holding the instruction and the registers
  a_req_stable: assert property (
    @(posedge clk) disable iff (rst)
    (lsu_vld && !lsu_rdy) |=>
      ($stable(lsu_adr) && $stable(lsu_wen) && $stable(lsu_wdt))
  );

endmodule

//--- rtl/rv_core.sv
module rv_core #(
  parameter rv_pkg::xlen_t RST_ADR = '0
) (
  input  logic          clk,
  input  logic          rst,
  // instruction fetch bus
  output logic          ifu_vld,
  output rv_pkg::xlen_t ifu_adr,
  input  logic          ifu_rdy,
  input  rv_pkg::inst_t ifu_rdt,
  // load/store bus
  output logic          lsu_vld,
  output logic          lsu_wen,
  output rv_pkg::xlen_t lsu_adr,
  output rv_pkg::xlen_t lsu_wdt,
  input  logic          lsu_rdy,
  input  rv_pkg::xlen_t lsu_rdt
);

  // fetch and pc
  logic             ifu_run;
  logic             ifu_trn;
  logic             ifu_new;
  logic             ifu_tkn;
  rv_pkg::xlen_t    ifu_pc;
  rv_pkg::xlen_t    ifu_pcn;
  rv_pkg::xlen_t    ifu_pci;
  rv_pkg::xlen_t    ifu_pct;
  logic             stall;
  // decode
  logic             idu_vld;
  rv_pkg::inst_t    idu_ins;
  rv_pkg::inst_t    idu_ins_q;
  rv_pkg::opc_t     idu_opc;
  rv_pkg::fn3_t     idu_fn3;
  // execute
  rv_pkg::xlen_t    gpr_rs1;
  rv_pkg::xlen_t    gpr_rs2;
  rv_pkg::alu_op_t  alu_op;
  rv_pkg::xlen_t    alu_b;
  rv_pkg::xlen_t    alu_res;
  logic             alu_eq;
  rv_pkg::xlen_t    lsu_ofs;
  rv_pkg::xlen_t    lsu_dat;
  logic             lsu_stl;
  // write back
  logic             wbu_wen;
  rv_pkg::xlen_t    wbu_dat;

  ////////////////////
  // fetch
  ////////////////////

  // fetch request goes up one cycle after reset
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      ifu_run <= 1'b0;
    end else begin
      ifu_run <= 1'b1;
    end
  end

  assign ifu_vld = ifu_run;
  assign ifu_adr = ifu_pcn;
  assign ifu_trn = ifu_vld & ifu_rdy;

  // either bus waiting
  assign stall = (ifu_vld & ~ifu_rdy) | lsu_stl;

  // ifu_rdt is fresh only after a fetch that retired the previous instruction;
  // a fetch during a data stall refetches the same next address
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      idu_vld <= 1'b0;
      ifu_new <= 1'b0;
    end else begin
      idu_vld <= ifu_trn | (idu_vld & stall);
      ifu_new <= ifu_trn & ~stall;
    end
  end

  // held copy of the instruction in decode
  assign idu_ins = ifu_new ? ifu_rdt : idu_ins_q;

  always_ff @(posedge clk) begin
    idu_ins_q <= idu_ins;
  end

  ////////////////////
  // program counter
  ////////////////////

  // sequential and jump/branch targets
  assign ifu_pci = ifu_pc + 32'd4;
  assign ifu_pct = ifu_pc + ((idu_opc == rv_pkg::JAL) ? rv_pkg::imm_j(idu_ins)
                                                      : rv_pkg::imm_b(idu_ins));

  // branch condition from the ALU compare
  always_comb begin
    case (idu_fn3)
      rv_pkg::FN3_BEQ: ifu_tkn = alu_eq;
      rv_pkg::FN3_BNE: ifu_tkn = ~alu_eq;
      default:         ifu_tkn = 1'b0;
    endcase
  end

  // next pc, also the fetch address, stays put without a valid instruction
  always_comb begin
    if (!idu_vld) begin
      ifu_pcn = ifu_pc;
    end else if ((idu_opc == rv_pkg::JAL) || ((idu_opc == rv_pkg::BRANCH) && ifu_tkn)) begin
      ifu_pcn = ifu_pct;
    end else begin
      ifu_pcn = ifu_pci;
    end
  end

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      ifu_pc <= RST_ADR;
    end else if (idu_vld && !stall) begin
      ifu_pc <= ifu_pcn;
    end
  end

  a_pc_aligned: assert property (
    @(posedge clk) disable iff (rst) ifu_pc[1:0] == 2'b00
  );

  ////////////////////
  // decode
  ////////////////////

  // unknown opcodes fall to the defaults and act as no-ops
  assign idu_opc = rv_pkg::opc_t'(idu_ins[rv_pkg::OPC_W-1:0]);
  assign idu_fn3 = idu_ins[14:12];

  // ALU operation and second operand
  always_comb begin
    alu_op = rv_pkg::ADD;
    alu_b  = gpr_rs2;
    case (idu_opc)
      rv_pkg::OP_IMM, rv_pkg::OP: begin
        if (idu_opc == rv_pkg::OP_IMM) begin
          alu_b = rv_pkg::imm_i(idu_ins);
        end
        case (idu_fn3)
          rv_pkg::FN3_XOR: alu_op = rv_pkg::XOR;
          rv_pkg::FN3_OR:  alu_op = rv_pkg::OR;
          rv_pkg::FN3_AND: alu_op = rv_pkg::AND;
          // SUB only for register-register with bit 30 set
          rv_pkg::FN3_ADD: begin
            alu_op = ((idu_opc == rv_pkg::OP) && idu_ins[30]) ? rv_pkg::SUB : rv_pkg::ADD;
          end
          default: alu_op = rv_pkg::ADD;
        endcase
      end
      rv_pkg::LUI: begin
        alu_op = rv_pkg::PASS_B;
        alu_b  = rv_pkg::imm_u(idu_ins);
      end
      // compare rs1 against rs2
      rv_pkg::BRANCH: alu_op = rv_pkg::SUB;
      default: alu_op = rv_pkg::ADD;
    endcase
  end

  // load/store offset
  assign lsu_ofs = (idu_opc == rv_pkg::STORE) ? rv_pkg::imm_s(idu_ins)
                                              : rv_pkg::imm_i(idu_ins);

  ////////////////////
  // execute
  ////////////////////

  rv_gpr gpr_i (
    .clk     (clk),
    .rst     (rst),
    .rs1_adr (idu_ins[19:15]),
    .rs2_adr (idu_ins[24:20]),
    .rs1_dat (gpr_rs1),
    .rs2_dat (gpr_rs2),
    .rd_adr  (idu_ins[11:7]),
    .rd_wen  (wbu_wen),
    .rd_dat  (wbu_dat)
  );

  rv_alu alu_i (
    .op  (alu_op),
    .a   (gpr_rs1),
    .b   (alu_b),
    .res (alu_res),
    .eq  (alu_eq)
  );

  // data access waits for fetch ready, so each data transfer retires
  rv_lsu lsu_i (
    .clk     (clk),
    .rst     (rst),
    .run     (idu_vld & ifu_rdy),
    .opc     (idu_opc),
    .base    (gpr_rs1),
    .ofs     (lsu_ofs),
    .wdt     (gpr_rs2),
    .lsu_vld (lsu_vld),
    .lsu_wen (lsu_wen),
    .lsu_adr (lsu_adr),
    .lsu_wdt (lsu_wdt),
    .lsu_rdy (lsu_rdy),
    .lsu_rdt (lsu_rdt),
    .rdt     (lsu_dat),
    .stl     (lsu_stl)
  );

  ////////////////////
  // write back
  ////////////////////

  // LUI takes the U immediate through the ALU pass path
  always_comb begin
    wbu_wen = idu_vld & ~stall;
    case (idu_opc)
      rv_pkg::OP_IMM, rv_pkg::OP, rv_pkg::LUI: wbu_dat = alu_res;
      rv_pkg::LOAD:                            wbu_dat = lsu_dat;
      // link address
      rv_pkg::JAL:                             wbu_dat = ifu_pci;
      default: begin
        wbu_dat = '0;
        wbu_wen = 1'b0;
      end
    endcase
  end

endmodule

//--- testbench/rv_tb_ref.svh
// instruction-set model of the kept RV32I subset
// walks the program from RST_ADR up to the jump to itself
function automatic void run_reference();
  rv_pkg::xlen_t regs [32];
  rv_pkg::xlen_t mem [32];
  rv_pkg::xlen_t pc;
  rv_pkg::xlen_t nxt;
  rv_pkg::xlen_t a;
  rv_pkg::xlen_t b;
  rv_pkg::xlen_t imm;
  rv_pkg::xlen_t adr;
  rv_pkg::xlen_t res;
  rv_pkg::inst_t ins;
  logic wr;
  for (int i = 0; i < 32; i++) begin
    regs[i] = '0;
    mem[i] = fill_data(DAT_ADR + 32'(4 * i));
  end
  exp_fetch.delete();
  exp_st_adr.delete();
  exp_st_dat.delete();
  pc = RST_ADR;
  n_exec = 0;
  exp_fetch.push_back(pc);
  while (n_exec < STEP_MAX) begin
    ins = imem[pc[7:2]];
    a = regs[ins[19:15]];
    b = regs[ins[24:20]];
    imm = {{20{ins[31]}}, ins[31:20]};
    nxt = pc + 32'd4;
    wr = 1'b0;
    res = '0;
    case (ins[6:0])
      // immediate and register-register arithmetic, bit 5 picks rs2
      7'b0010011, 7'b0110011: begin
        if (!ins[5]) begin
          b = imm;
        end
        wr = 1'b1;
        case (ins[14:12])
          3'b000: res = (ins[5] && ins[30]) ? a - b : a + b;
          3'b100: res = a ^ b;
          3'b110: res = a | b;
          3'b111: res = a & b;
          default: wr = 1'b0;
        endcase
      end
      // lui
      7'b0110111: begin
        wr = 1'b1;
        res = {ins[31:12], 12'h000};
      end
      // lw
      7'b0000011: begin
        wr = 1'b1;
        adr = a + imm;
        res = mem[adr[6:2]];
      end
      // sw, logged in program order
      7'b0100011: begin
        adr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
        mem[adr[6:2]] = b;
        exp_st_adr.push_back(adr);
        exp_st_dat.push_back(b);
      end
      // beq and bne
      7'b1100011: begin
        if (((ins[14:12] == 3'b000) && (a == b)) || ((ins[14:12] == 3'b001) && (a != b))) begin
          nxt = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        end
      end
      // jal with link
      7'b1101111: begin
        wr = 1'b1;
        res = pc + 32'd4;
        nxt = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
      end
      default: begin
        wr = 1'b0;
      end
    endcase
    if (wr && (ins[11:7] != 5'd0)) begin
      regs[ins[11:7]] = res;
    end
    n_exec++;
    exp_fetch.push_back(nxt);
    if (nxt == pc) begin
      break;
    end
    pc = nxt;
  end
endfunction

//--- testbench/rv_core_tb.sv
module rv_core_tb;

  localparam rv_pkg::xlen_t RST_ADR = 32'h0000_0100;
  localparam rv_pkg::xlen_t DAT_ADR = 32'h0000_0200;
  // longest run of ready low on either bus
  localparam int unsigned MAX_WAIT = 3;
  localparam int unsigned STEP_MAX = 500;

  logic          clk = 1'b0;
  logic          rst = 1'b1;
  logic          ifu_vld;
  rv_pkg::xlen_t ifu_adr;
  logic          ifu_rdy = 1'b0;
  rv_pkg::inst_t ifu_rdt = '0;
  logic          lsu_vld;
  logic          lsu_wen;
  rv_pkg::xlen_t lsu_adr;
  rv_pkg::xlen_t lsu_wdt;
  logic          lsu_rdy = 1'b0;
  rv_pkg::xlen_t lsu_rdt;

  // memories, 64 instruction words at RST_ADR, 32 data words at DAT_ADR
  rv_pkg::inst_t imem [64];
  rv_pkg::xlen_t dmem [32];
  rv_pkg::inst_t prog [$];
  // expected sequences
  rv_pkg::xlen_t exp_fetch [$];
  rv_pkg::xlen_t exp_st_adr [$];
  rv_pkg::xlen_t exp_st_dat [$];
  int unsigned   n_exec = 0;
  // run control
  int unsigned   rdy_pct = 100;
  int unsigned   ifu_wait = 0;
  int unsigned   lsu_wait = 0;
  int unsigned   fe_cnt = 0;
  int unsigned   st_cnt = 0;
  int unsigned   cyc_cnt = 0;
  int unsigned   cyc_max = 0;
  string         phase = "reset";

  rv_core #(
    .RST_ADR (RST_ADR)
  ) rv_core_i (
    .clk     (clk),
    .rst     (rst),
    .ifu_vld (ifu_vld),
    .ifu_adr (ifu_adr),
    .ifu_rdy (ifu_rdy),
    .ifu_rdt (ifu_rdt),
    .lsu_vld (lsu_vld),
    .lsu_wen (lsu_wen),
    .lsu_adr (lsu_adr),
    .lsu_wdt (lsu_wdt),
    .lsu_rdy (lsu_rdy),
    .lsu_rdt (lsu_rdt)
  );

  always #20 clk = ~clk;

  ////////////////////
  // helpers
  ////////////////////

  // memory contents spread over the whole address
  function automatic rv_pkg::xlen_t fill_data(rv_pkg::xlen_t adr);
    return (adr * 32'h0001_0003) ^ 32'h5a5a_0000;
  endfunction

  // unknown opcode 7'h7f, never executed
  function automatic rv_pkg::inst_t fill_inst(rv_pkg::xlen_t adr);
    return (adr * 32'h9e37_79b1) | 32'h0000_007f;
  endfunction

  // instruction encoders
  function automatic rv_pkg::inst_t i_type(logic [6:0] opc, rv_pkg::fn3_t fn3,
                                           rv_pkg::reg_idx_t rd, rv_pkg::reg_idx_t rs1,
                                           logic [11:0] imm);
    return {imm, rs1, fn3, rd, opc};
  endfunction

  function automatic rv_pkg::inst_t r_type(logic [6:0] fn7, rv_pkg::fn3_t fn3,
                                           rv_pkg::reg_idx_t rd, rv_pkg::reg_idx_t rs1,
                                           rv_pkg::reg_idx_t rs2);
    return {fn7, rs2, rs1, fn3, rd, 7'b0110011};
  endfunction

  function automatic rv_pkg::inst_t s_type(rv_pkg::reg_idx_t rs2, rv_pkg::reg_idx_t rs1,
                                           logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic rv_pkg::inst_t b_type(rv_pkg::fn3_t fn3, rv_pkg::reg_idx_t rs1,
                                           rv_pkg::reg_idx_t rs2, logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, fn3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic rv_pkg::inst_t j_type(rv_pkg::reg_idx_t rd, logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  function automatic rv_pkg::inst_t u_type(rv_pkg::reg_idx_t rd, logic [19:0] imm);
    return {imm, rd, 7'b0110111};
  endfunction

  `include "rv_tb_ref.svh"

  // past the end of the list the core spins on the last address
  function automatic rv_pkg::xlen_t expected_fetch(int unsigned idx);
    return (idx < exp_fetch.size()) ? exp_fetch[idx] : exp_fetch[exp_fetch.size() - 1];
  endfunction

  task automatic stop_run(string what);
    $display("%s", what);
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  task automatic check_adr(string name, rv_pkg::xlen_t exp, rv_pkg::xlen_t act);
    if (exp !== act) begin
      stop_run($sformatf("ERROR %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_dat(string name, rv_pkg::xlen_t exp, rv_pkg::xlen_t act);
    if (exp !== act) begin
      stop_run($sformatf("ERROR %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic load_program();
    prog.delete();
    // data base and operands, x3 = -3
    prog.push_back(i_type(rv_pkg::OP_IMM, 3'b000, 5'd1, 5'd0, 12'h200));
    prog.push_back(i_type(rv_pkg::OP_IMM, 3'b000, 5'd2, 5'd0, 12'h005));
    prog.push_back(i_type(rv_pkg::OP_IMM, 3'b000, 5'd3, 5'd0, 12'hffd));
    // add sub and or xor
    prog.push_back(r_type(7'h00, 3'b000, 5'd4, 5'd2, 5'd3));
    prog.push_back(r_type(7'h20, 3'b000, 5'd5, 5'd2, 5'd3));
    prog.push_back(r_type(7'h00, 3'b111, 5'd6, 5'd2, 5'd3));
    prog.push_back(r_type(7'h00, 3'b110, 5'd7, 5'd2, 5'd3));
    prog.push_back(r_type(7'h00, 3'b100, 5'd8, 5'd2, 5'd3));
    // xori ori andi lui
    prog.push_back(i_type(rv_pkg::OP_IMM, 3'b100, 5'd9, 5'd2, 12'h0f0));
    prog.push_back(i_type(rv_pkg::OP_IMM, 3'b110, 5'd10, 5'd2, 12'h300));
    prog.push_back(i_type(rv_pkg::OP_IMM, 3'b111, 5'd11, 5'd3, 12'h7f0));
    prog.push_back(u_type(5'd12, 20'habcde));
    // x4..x12 to words 0..8
    for (int r = 4; r <= 12; r++) begin
      prog.push_back(s_type(5'(r), 5'd1, 12'(4 * (r - 4))));
    end
    // loads of preloaded words, then of a stored word
    prog.push_back(i_type(rv_pkg::LOAD, 3'b010, 5'd13, 5'd1, 12'd64));
    prog.push_back(i_type(rv_pkg::OP_IMM, 3'b000, 5'd13, 5'd13, 12'h001));
    prog.push_back(i_type(rv_pkg::LOAD, 3'b010, 5'd14, 5'd1, 12'd68));
    prog.push_back(r_type(7'h00, 3'b100, 5'd15, 5'd13, 5'd14));
    prog.push_back(s_type(5'd15, 5'd1, 12'd36));
    prog.push_back(i_type(rv_pkg::LOAD, 3'b010, 5'd16, 5'd1, 12'd0));
    prog.push_back(r_type(7'h00, 3'b000, 5'd16, 5'd16, 5'd12));
    prog.push_back(s_type(5'd16, 5'd1, 12'd40));
    // branches taken and not taken
    prog.push_back(b_type(3'b000, 5'd2, 5'd2, 13'd8));
    prog.push_back(i_type(rv_pkg::OP_IMM, 3'b000, 5'd20, 5'd0, 12'h001));
    prog.push_back(b_type(3'b001, 5'd2, 5'd2, 13'd8));
    prog.push_back(i_type(rv_pkg::OP_IMM, 3'b000, 5'd21, 5'd0, 12'h007));
    prog.push_back(b_type(3'b000, 5'd2, 5'd3, 13'd8));
    prog.push_back(b_type(3'b001, 5'd2, 5'd3, 13'd8));
    prog.push_back(i_type(rv_pkg::OP_IMM, 3'b000, 5'd21, 5'd21, 12'd100));
    prog.push_back(s_type(5'd20, 5'd1, 12'd44));
    prog.push_back(s_type(5'd21, 5'd1, 12'd48));
    // jal over one word, link stored
    prog.push_back(j_type(5'd22, 21'd8));
    prog.push_back(i_type(rv_pkg::OP_IMM, 3'b000, 5'd22, 5'd0, 12'h000));
    prog.push_back(s_type(5'd22, 5'd1, 12'd52));
    // three turns of a backward loop
    prog.push_back(i_type(rv_pkg::OP_IMM, 3'b000, 5'd23, 5'd0, 12'h003));
    prog.push_back(i_type(rv_pkg::OP_IMM, 3'b000, 5'd23, 5'd23, 12'hfff));
    prog.push_back(i_type(rv_pkg::OP_IMM, 3'b000, 5'd24, 5'd24, 12'h002));
    prog.push_back(b_type(3'b001, 5'd23, 5'd0, 13'h1ff8));
    prog.push_back(s_type(5'd24, 5'd1, 12'd56));
    // write to x0 then store it
    prog.push_back(i_type(rv_pkg::OP_IMM, 3'b000, 5'd0, 5'd2, 12'h009));
    prog.push_back(s_type(5'd0, 5'd1, 12'd60));
    // halt
    prog.push_back(j_type(5'd0, 21'd0));
    for (int i = 0; i < 64; i++) begin
      imem[i] = (i < prog.size()) ? prog[i] : fill_inst(RST_ADR + 32'(4 * i));
    end
  endtask

  task automatic run_phase(string name, int unsigned pct);
    rst <= 1'b1;
    repeat (10) @(posedge clk);
    phase <= name;
    rdy_pct <= pct;
    rst <= 1'b0;
    @(posedge clk);
    while ((st_cnt < exp_st_adr.size()) || (fe_cnt < exp_fetch.size())) begin
      @(posedge clk);
    end
    // a repeated store would show up here
    repeat (20) @(posedge clk);
  endtask

  ////////////////////
  // bus models
  ////////////////////

  // random ready with a bounded low run
  always @(posedge clk) begin
    logic ir;
    logic lr;
    ir = (ifu_wait >= MAX_WAIT) || (($urandom % 100) < rdy_pct);
    lr = (lsu_wait >= MAX_WAIT) || (($urandom % 100) < rdy_pct);
    ifu_rdy <= ir;
    lsu_rdy <= lr;
    ifu_wait <= ir ? 0 : ifu_wait + 1;
    lsu_wait <= lr ? 0 : lsu_wait + 1;
  end

  // instruction one cycle after the transfer, data reloaded in reset
  always @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        dmem[i] <= fill_data(DAT_ADR + 32'(4 * i));
      end
    end else begin
      if (ifu_vld && ifu_rdy) begin
        ifu_rdt <= imem[ifu_adr[7:2]];
      end
      if (lsu_vld && lsu_rdy && lsu_wen) begin
        dmem[lsu_adr[6:2]] <= lsu_wdt;
      end
    end
  end

  // load data in the transfer cycle
  assign lsu_rdt = dmem[lsu_adr[6:2]];

  ////////////////////
  // compare
  ////////////////////

  // a fetch counts once it is not held by a data stall
  always @(posedge clk) begin
    if (rst) begin
      fe_cnt <= 0;
      st_cnt <= 0;
      cyc_cnt <= 0;
      if (ifu_vld || lsu_vld) begin
        stop_run("a bus valid was high while reset was asserted");
      end
    end else if (cyc_cnt >= cyc_max) begin
      stop_run($sformatf("timeout in phase %s after %0d cycles", phase, cyc_cnt));
    end else if (ifu_vld && ifu_rdy && (ifu_adr[31:8] != RST_ADR[31:8])) begin
      stop_run($sformatf("fetch from %h is outside the instruction memory", ifu_adr));
    end else if (lsu_vld && lsu_rdy && (lsu_adr[31:7] != DAT_ADR[31:7])) begin
      stop_run($sformatf("data access at %h is outside the data memory", lsu_adr));
    end else if (lsu_vld && lsu_rdy && lsu_wen && (st_cnt >= exp_st_adr.size())) begin
      stop_run("a store happened after the last expected store");
    end else begin
      cyc_cnt <= cyc_cnt + 1;
      if (ifu_vld && ifu_rdy && !(lsu_vld && !lsu_rdy)) begin
        check_adr({phase, " fetch adr"}, expected_fetch(fe_cnt), ifu_adr);
        fe_cnt <= fe_cnt + 1;
      end
      if (lsu_vld && lsu_rdy && lsu_wen) begin
        check_adr({phase, " store adr"}, exp_st_adr[st_cnt], lsu_adr);
        check_dat({phase, " store dat"}, exp_st_dat[st_cnt], lsu_wdt);
        st_cnt <= st_cnt + 1;
      end
    end
  end

  initial begin
    void'($urandom(32'ha7a1));
    load_program();
    run_reference();
    cyc_max = n_exec * (2 + MAX_WAIT) * 4;
    run_phase("no_stall", 100);
    run_phase("ready_70", 70);
    run_phase("ready_35", 35);
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

//--- vlog.f
+incdir+testbench
rtl/rv_pkg.sv
rtl/rv_gpr.sv
rtl/rv_alu.sv
rtl/rv_lsu.sv
rtl/rv_core.sv
testbench/rv_core_tb.sv

//--- run.sh
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module rv_core_tb -f vlog.f -o rv_core_tb_sim
# the pipeline status is that of grep
./obj_dir/rv_core_tb_sim | tee /dev/stderr | grep -F -q "ALL CHECKS PASSED"
